/* aesAccel.f */
aesPkg.sv
aesKeySchedule.sv
aesRoundUnit.sv
aesCore.sv
aesAxiRegs.sv
aesAccel.sv
aesAccelTb.sv

/* Bender.yml */
package:
  name: aesAccel

sources:
  - aesPkg.sv
  - aesKeySchedule.sv
  - aesRoundUnit.sv
  - aesCore.sv
  - aesAxiRegs.sv
  - aesAccel.sv
  - target: test
    files:
      - aesAccelTb.sv

/* aesAccelTb.sv */
module aesAccelTb import aesPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// room for about 40 encryptions of about 100 bus and cipher cycles each
	localparam int maxCycles = 4000;

	localparam aesBlock_t fipsKey = {32'h0f0e0d0c, 32'h0b0a0908, 32'h07060504, 32'h03020100};
	localparam aesBlock_t fipsPlain = {32'hffeeddcc, 32'hbbaa9988, 32'h77665544, 32'h33221100};
	localparam aesBlock_t fipsCipher = {32'h5ac5b470, 32'h80b7cdd8, 32'h30047b6a, 32'hd8e0c469};

	logic clk;
	logic rst_n;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	logic [7:0] sTab [256];
	aesBlock_t gotQ [$];
	aesBlock_t expQ [$];
	int nSent;
	int nCompared;
	int cycleCnt;

	aesAccel #(.addrWidth(8)) dut0 (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= maxCycles) begin
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout, the run did not finish within %0d cycles", maxCycles);
		end
	end

	task automatic checkBlock(input string name, input aesBlock_t got, input aesBlock_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "block mismatch on %s", name);
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "word mismatch on %s", name);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "bit mismatch on %s", name);
		end
	endtask

	// GF(2^8) product modulo 0x11b
	function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		p = 8'h00;
		for (int i = 0; i < 8; i++) begin
			if (b[i]) begin
				p = p ^ a;
			end
			a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// byte i of the block is row i % 4 of column i / 4
	function automatic aesBlock_t aesEncrypt(input aesBlock_t key, input aesBlock_t pt);
		logic [7:0] s [16];
		logic [7:0] t [16];
		logic [7:0] w [176];
		logic [7:0] rc;
		aesBlock_t out;
		rc = 8'h01;
		for (int i = 0; i < 16; i++) begin
			w[i] = key[i / 4].bytes[i % 4];
			s[i] = pt[i / 4].bytes[i % 4] ^ w[i];
		end
		for (int i = 16; i < 176; i += 4) begin
			if (i % 16 == 0) begin
				w[i] = w[i - 16] ^ sTab[w[i - 3]] ^ rc;
				w[i + 1] = w[i - 15] ^ sTab[w[i - 2]];
				w[i + 2] = w[i - 14] ^ sTab[w[i - 1]];
				w[i + 3] = w[i - 13] ^ sTab[w[i - 4]];
				rc = gmul(rc, 8'h02);
			end else begin
				for (int j = 0; j < 4; j++) begin
					w[i + j] = w[i + j - 16] ^ w[i + j - 4];
				end
			end
		end
		for (int rnd = 1; rnd <= 10; rnd++) begin
			for (int i = 0; i < 16; i++) begin
				t[i] = sTab[s[(i + 4 * (i % 4)) % 16]];
			end
			for (int c = 0; c < 4; c++) begin
				for (int r = 0; r < 4; r++) begin
					if (rnd < 10) begin
						s[4 * c + r] = gmul(t[4 * c + r], 8'h02)
							^ gmul(t[4 * c + (r + 1) % 4], 8'h03)
							^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
					end else begin
						s[4 * c + r] = t[4 * c + r];
					end
					s[4 * c + r] = s[4 * c + r] ^ w[16 * rnd + 4 * c + r];
				end
			end
		end
		for (int i = 0; i < 16; i++) begin
			out[i / 4].bytes[i % 4] = s[i];
		end
		return out;
	endfunction

	function automatic aesBlock_t randBlock();
		aesBlock_t b;
		for (int i = 0; i < 4; i++) begin
			b[i].word = $urandom();
		end
		return b;
	endfunction

	task automatic axiWrite(input logic [4:0] idx, input logic [31:0] data);
		@(posedge clk);
		awaddr <= {1'b0, idx, 2'b00};
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat ($urandom_range(2)) @(posedge clk);
		bready <= 1'b1;
		do @(negedge clk); while (!bvalid);
		checkWord("bresp", {30'd0, bresp}, 32'd0);
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [4:0] idx, output logic [31:0] data);
		@(posedge clk);
		araddr <= {1'b0, idx, 2'b00};
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		repeat ($urandom_range(2)) @(posedge clk);
		rready <= 1'b1;
		do @(negedge clk); while (!rvalid);
		checkWord("rresp", {30'd0, rresp}, 32'd0);
		data = rdata;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic writeBlock(input logic [4:0] base, input aesBlock_t b);
		for (int i = 0; i < 4; i++) begin
			axiWrite(base + 5'(i), b[i].word);
		end
	endtask

	task automatic readBlock(input logic [4:0] base, output aesBlock_t b);
		for (int i = 0; i < 4; i++) begin
			axiRead(base + 5'(i), b[i].word);
		end
	endtask

	task automatic waitDone();
		logic [31:0] st;
		do begin
			axiRead(regCtrl, st);
		end while (!st[ctrlDoneBit]);
		axiRead(regCounter, st);
		checkWord("counter", st, 32'd11);
	endtask

	task automatic collectResult(input aesBlock_t key, input aesBlock_t pt);
		aesBlock_t ct;
		readBlock(regCipher0, ct);
		gotQ.push_back(ct);
		expQ.push_back(aesEncrypt(key, pt));
		nSent++;
	endtask

	// a nonzero intrude is a word index written while the core is busy
	task automatic encryptOnBus(input aesBlock_t key, input aesBlock_t pt,
		input logic [4:0] intrude);
		writeBlock(regKey0, key);
		writeBlock(regPlain0, pt);
		axiWrite(regCtrl, 32'd1 << ctrlGoBit);
		if (intrude != 5'd0) begin
			axiWrite(intrude, $urandom());
		end
		waitDone();
		collectResult(key, pt);
	endtask

	always @(negedge clk) begin
		while (gotQ.size() > 0) begin
			checkBlock("ciphertext", gotQ.pop_front(), expQ.pop_front());
			nCompared++;
		end
	end

	initial begin
		aesBlock_t key;
		aesBlock_t pt;
		aesBlock_t rb;
		logic [31:0] val;
		logic [7:0] inv;
		void'($urandom(89));
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		// S-box as the affine map of the multiplicative inverse b^254
		for (int b = 0; b < 256; b++) begin
			inv = 8'h01;
			for (int e = 0; e < 254; e++) begin
				inv = gmul(inv, 8'(b));
			end
			sTab[b] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
				^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
		end
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < 32; i++) begin
			axiRead(5'(i), val);
			checkWord($sformatf("word %0d after reset", i), val, 32'd0);
		end

		key = randBlock();
		pt = randBlock();
		writeBlock(regKey0, key);
		writeBlock(regPlain0, pt);
		readBlock(regKey0, rb);
		checkBlock("key readback", rb, key);
		readBlock(regPlain0, rb);
		checkBlock("plaintext readback", rb, pt);

		encryptOnBus(fipsKey, fipsPlain, 5'd0);
		readBlock(regCipher0, rb);
		checkBlock("fips ciphertext", rb, fipsCipher);

		// read-only words ignore writes
		axiWrite(regCounter, 32'hffffffff);
		axiWrite(regCipher0, 32'hffffffff);
		axiRead(regCounter, val);
		checkWord("counter after write", val, 32'd11);
		readBlock(regCipher0, rb);
		checkBlock("ciphertext after write", rb, fipsCipher);

		// unmapped words stay zero with every register loaded
		for (int i = 0; i < 32; i++) begin
			if (i < regCtrl || i > regCipher0 + 3) begin
				axiRead(5'(i), val);
				checkWord($sformatf("unmapped word %0d", i), val, 32'd0);
			end
		end

		repeat (30) begin
			encryptOnBus(randBlock(), randBlock(), 5'd0);
		end

		// writes that land while the block is in flight
		for (int i = 0; i < 2; i++) begin
			key = randBlock();
			pt = randBlock();
			encryptOnBus(key, pt, i == 0 ? regKey0 : regPlain0 + 5'd3);
			readBlock(regKey0, rb);
			checkBlock("key after busy write", rb, key);
			readBlock(regPlain0, rb);
			checkBlock("plaintext after busy write", rb, pt);
		end

		axiWrite(regCtrl, 32'd1 << ctrlGoBit);
		axiRead(regCtrl, val);
		checkBit("done after new go", val[ctrlDoneBit], 1'b0);
		checkBit("go readback", val[ctrlGoBit], 1'b0);
		waitDone();
		collectResult(key, pt);

		repeat (2) @(negedge clk);
		if (nCompared == nSent && gotQ.size() == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("only %0d of %0d ciphertexts were compared", nCompared, nSent);
			$display("TESTBENCH FAILED");
			$fatal(1, "ciphertext comparisons missing");
		end
	end

endmodule

/* aesAccel.sv */
module aesAccel import aesPkg::*; #(
	parameter int addrWidth = 8
) (
	input logic clk,
	input logic rst_n,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic start;
	logic busy;
	logic done;
	logic [15:0] cycleCount;
	aesBlock_t key;
	aesBlock_t plaintext;
	aesBlock_t ciphertext;

	aesAxiRegs #(
		.addrWidth(addrWidth)
	) axiRegs0 (
		.clk(clk),
		.rst_n(rst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.busy(busy),
		.done(done),
		.ciphertext(ciphertext),
		.cycleCount(cycleCount),
		.start(start),
		.key(key),
		.plaintext(plaintext)
	);

	aesCore core0 (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.key(key),
		.plaintext(plaintext),
		.busy(busy),
		.done(done),
		.ciphertext(ciphertext),
		.cycleCount(cycleCount)
	);

endmodule

/* aesAxiRegs.sv */
module aesAxiRegs import aesPkg::*; #(
	parameter int addrWidth = 8
) (
	input logic clk,
	input logic rst_n,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	input logic done,
	input aesBlock_t ciphertext,
	input logic [15:0] cycleCount,
	output logic start,
	output aesBlock_t key,
	output aesBlock_t plaintext
);

	logic wrAccept;
	logic rdAccept;
	logic [4:0] wrIdx;
	logic [4:0] rdIdx;
	logic [4:0] wrKeyOff;
	logic [4:0] wrPlainOff;
	logic [4:0] rdKeyOff;
	logic [4:0] rdPlainOff;
	logic [4:0] rdCipherOff;
	logic [31:0] readWord;

	assign wrAccept = awready && wready && awvalid && wvalid;
	assign rdAccept = arready && arvalid;

	assign wrIdx = awaddr[6:2];
	assign rdIdx = araddr[6:2];
	assign wrKeyOff = wrIdx - regKey0;
	assign wrPlainOff = wrIdx - regPlain0;
	assign rdKeyOff = rdIdx - regKey0;
	assign rdPlainOff = rdIdx - regPlain0;
	assign rdCipherOff = rdIdx - regCipher0;

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	// go only takes effect when the core is idle
	assign start = wrAccept && wrIdx == regCtrl && wdata[ctrlGoBit] && !busy;

	// write channel accepts AW and W together
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			if (wrAccept) begin
				bvalid <= 1'b1;
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// key and plaintext frozen while a block is in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			key <= '0;
			plaintext <= '0;
		end else if (wrAccept && !busy) begin
			if (wrIdx inside {[regKey0:regKey0 + 5'd3]}) begin
				key[wrKeyOff[1:0]].word <= wdata;
			end
			if (wrIdx inside {[regPlain0:regPlain0 + 5'd3]}) begin
				plaintext[wrPlainOff[1:0]].word <= wdata;
			end
		end
	end

	// go reads back as 0
	always_comb begin
		readWord = 32'd0;
		if (rdIdx == regCtrl) begin
			readWord[ctrlDoneBit] = done;
		end else if (rdIdx == regCounter) begin
			readWord = {16'd0, cycleCount};
		end else if (rdIdx inside {[regKey0:regKey0 + 5'd3]}) begin
			readWord = key[rdKeyOff[1:0]].word;
		end else if (rdIdx inside {[regPlain0:regPlain0 + 5'd3]}) begin
			readWord = plaintext[rdPlainOff[1:0]].word;
		end else if (rdIdx inside {[regCipher0:regCipher0 + 5'd3]}) begin
			readWord = ciphertext[rdCipherOff[1:0]].word;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= 32'd0;
		end else begin
			arready <= arvalid && !rvalid && !arready;
			if (rdAccept) begin
				rvalid <= 1'b1;
				rdata <= readWord;
			end else if (rvalid && rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	bvalidAfterAccept: assert property (
		@(posedge clk) disable iff (!rst_n)
		$rose(bvalid) |-> $past(wrAccept)
	);

	// full-word writes only
	fullWordWrite: assert property (
		@(posedge clk) disable iff (!rst_n)
		wrAccept |-> wstrb == 4'hf
	);

endmodule

/* aesCore.sv */
module aesCore import aesPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input aesBlock_t key,
	input aesBlock_t plaintext,
	output logic busy,
	output logic done,
	output aesBlock_t ciphertext,
	output logic [15:0] cycleCount
);

	aesRound_t roundIdx;
	aesBlock_t roundKey;
	logic round;
	logic finalRound;
	logic advance;
	logic wrapUp;

	// index 0 while busy is the cycle after the final round
	assign round = busy && roundIdx != 4'd0 && roundIdx < numRounds;
	assign finalRound = busy && roundIdx == numRounds;
	assign wrapUp = busy && roundIdx == 4'd0;
	assign advance = round || finalRound;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			roundIdx <= '0;
			cycleCount <= '0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
			roundIdx <= 4'd1;
			cycleCount <= '0;
		end else if (busy) begin
			cycleCount <= cycleCount + 16'd1;
			if (wrapUp) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else if (finalRound) begin
				roundIdx <= '0;
			end else begin
				roundIdx <= roundIdx + 4'd1;
			end
		end
	end

	aesKeySchedule keySchedule0 (
		.clk(clk),
		.rst_n(rst_n),
		.load(start),
		.advance(advance),
		.key(key),
		.roundKey(roundKey)
	);

	aesRoundUnit roundUnit0 (
		.clk(clk),
		.rst_n(rst_n),
		.load(start),
		.round(round),
		.finalRound(finalRound),
		.plaintext(plaintext),
		.roundKey(roundKey),
		.state(ciphertext)
	);

	busyDoneExclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(busy && done)
	);

endmodule

/* aesRoundUnit.sv */
module aesRoundUnit import aesPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic round,
	input logic finalRound,
	input aesBlock_t plaintext,
	input aesBlock_t roundKey,
	output aesBlock_t state
);

	aesBlock_t shifted;
	aesBlock_t mixed;
	aesBlock_t nextState;

	// SubBytes and ShiftRows take row r of column c from column c + r
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[c].bytes[r] = sBox(state[(c + r) % 4].bytes[r]);
			end
		end
	end

	// MixColumns as 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				mixed[c].bytes[r] = xtime(shifted[c].bytes[r])
					^ xtime(shifted[c].bytes[(r + 1) % 4])
					^ shifted[c].bytes[(r + 1) % 4]
					^ shifted[c].bytes[(r + 2) % 4]
					^ shifted[c].bytes[(r + 3) % 4];
			end
		end
	end

	// AddRoundKey on whichever path is active
	always_comb begin
		if (load) begin
			nextState = plaintext ^ roundKey;
		end else if (finalRound) begin
			nextState = shifted ^ roundKey;
		end else begin
			nextState = mixed ^ roundKey;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= '0;
		end else if (load || round || finalRound) begin
			state <= nextState;
		end
	end

	roundFinalExclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(round && finalRound)
	);

endmodule

/* aesKeySchedule.sv */
module aesKeySchedule import aesPkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic advance,
	input aesBlock_t key,
	output aesBlock_t roundKey
);

	aesBlock_t curKey;
	aesBlock_t nextKey;
	logic [7:0] rcon;

	// next round key from the current one with rcon in the first word
	always_comb begin
		nextKey[0].word = curKey[0].word ^ subWord(rotWord(curKey[3].word)) ^ {24'd0, rcon};
		for (int i = 1; i < 4; i++) begin
			nextKey[i].word = curKey[i].word ^ nextKey[i - 1].word;
		end
	end

	// key for the round unit in this cycle
	assign roundKey = load ? key : nextKey;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rcon <= 8'h00;
		end else if (load) begin
			rcon <= 8'h01;
		end else if (advance) begin
			rcon <= xtime(rcon);
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			curKey <= key;
		end else if (advance) begin
			curKey <= nextKey;
		end
	end

	// a zero rcon here means advance came without a load first
	rconLive: assert property (
		@(posedge clk) disable iff (!rst_n)
		advance |-> rcon != 8'h00
	);

endmodule

/* aesPkg.sv */
package aesPkg;

	// one column of the state with byte 0 in bits 7:0
	typedef union packed {
		logic [31:0] word;
		logic [3:0][7:0] bytes;
	} aesWord_u;

	typedef aesWord_u [3:0] aesBlock_t;

	typedef logic [3:0] aesRound_t;

	localparam aesRound_t numRounds = 4'd10;

	// word indices taken from byte address bits 6:2
	localparam logic [4:0] regCtrl = 5'd8;
	localparam logic [4:0] regCounter = 5'd9;
	localparam logic [4:0] regKey0 = 5'd10;
	localparam logic [4:0] regPlain0 = 5'd14;
	localparam logic [4:0] regCipher0 = 5'd18;

	localparam int ctrlGoBit = 0;
	localparam int ctrlDoneBit = 31;

	localparam logic [7:0] sBoxTable [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	function automatic logic [7:0] sBox(input logic [7:0] b);
		return sBoxTable[b];
	endfunction

	// multiply by x in GF(2^8) modulo 0x11b
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [31:0] subWord(input logic [31:0] w);
		aesWord_u src;
		aesWord_u dst;
		src.word = w;
		for (int i = 0; i < 4; i++) begin
			dst.bytes[i] = sBox(src.bytes[i]);
		end
		return dst.word;
	endfunction

	// byte 1 moves down to byte 0 and byte 0 wraps to byte 3
	function automatic logic [31:0] rotWord(input logic [31:0] w);
		return {w[7:0], w[31:8]};
	endfunction

endpackage
